// ==== rtl/cpu_decode_pkg.sv ====
package cpu_decode_pkg;

    // datapath and register file geometry
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;   // 32 architectural registers

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // operation handed to the execute stage
    typedef enum logic [3:0] {
        alu_nop  = 4'd0,   // inactive value, also used for bubbles
        alu_add  = 4'd1,
        alu_sub  = 4'd2,
        alu_sll  = 4'd3,
        alu_slt  = 4'd4,
        alu_sltu = 4'd5,
        alu_xor  = 4'd6,
        alu_srl  = 4'd7,
        alu_sra  = 4'd8,
        alu_or   = 4'd9,
        alu_and  = 4'd10
    } alu_op_e;

    // memory stage request
    typedef enum logic [1:0] {
        mem_nop   = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

    // access width and sign extension for load write-back
    // stores reuse the same encoding to size the bus write
    typedef enum logic [2:0] {
        wb_word          = 3'd0,   // also the inactive value
        wb_byte_signed   = 3'd1,
        wb_half_signed   = 3'd2,
        wb_byte_unsigned = 3'd3,
        wb_half_unsigned = 3'd4
    } wb_type_e;

    // major opcodes, instr[6:0]
    localparam logic [6:0] opc_load   = 7'b000_0011;   // lb lh lw lbu lhu
    localparam logic [6:0] opc_store  = 7'b010_0011;   // sb sh sw
    localparam logic [6:0] opc_op_imm = 7'b001_0011;   // addi .. srai
    localparam logic [6:0] opc_op     = 7'b011_0011;   // add .. and
    localparam logic [6:0] opc_bubble = 7'b000_0000;   // inserted by the pipeline, no effect

endpackage

// ==== rtl/instr_capture.sv ====
`timescale 1ns/10ps

module instr_capture (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cpu_decode_pkg::word_t     instruction,
    input  logic                      instr_valid,
    input  cpu_decode_pkg::reg_addr_t rd_1c,
    input  cpu_decode_pkg::reg_addr_t rd_2c,
    input  cpu_decode_pkg::reg_addr_t rd_3c,
    input  cpu_decode_pkg::word_t     fwd_1c,
    input  cpu_decode_pkg::word_t     fwd_2c,
    input  cpu_decode_pkg::word_t     fwd_3c,
    output cpu_decode_pkg::word_t     instr_q,
    output logic                      valid_q,
    output cpu_decode_pkg::reg_addr_t rd_1c_q,
    output cpu_decode_pkg::reg_addr_t rd_2c_q,
    output cpu_decode_pkg::reg_addr_t rd_3c_q,
    output cpu_decode_pkg::word_t     fwd_1c_q,
    output cpu_decode_pkg::word_t     fwd_2c_q,
    output cpu_decode_pkg::word_t     fwd_3c_q
);
    import cpu_decode_pkg::*;

    localparam word_t bubble_word = {{(xlen-7){1'b0}}, opc_bubble};   // all-zero word

    // strobe and instruction word, idle slots become bubbles so the
    // register file addresses stay quiet between instructions
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            instr_q <= bubble_word;
        end else begin
            valid_q <= instr_valid;
            instr_q <= instr_valid ? instruction : bubble_word;
        end
    end

    // hazard snapshot taken on the same edge as the instruction,
    // keeps rd and forward value of each stage paired
    always_ff @(posedge clk) begin
        rd_1c_q  <= rd_1c;
        rd_2c_q  <= rd_2c;
        rd_3c_q  <= rd_3c;
        fwd_1c_q <= fwd_1c;   // combinational alu result of N-1
        fwd_2c_q <= fwd_2c;   // alu output of N-2
        fwd_3c_q <= fwd_3c;   // registered alu result of N-3
    end

endmodule

// ==== rtl/operand_forward.sv ====
`timescale 1ns/10ps

module operand_forward #(
    parameter bit enable_forwarding = 1'b1
) (
    input  cpu_decode_pkg::reg_addr_t src_addr,
    input  cpu_decode_pkg::word_t     rf_data,
    input  cpu_decode_pkg::reg_addr_t rd_1c,
    input  cpu_decode_pkg::reg_addr_t rd_2c,
    input  cpu_decode_pkg::reg_addr_t rd_3c,
    input  cpu_decode_pkg::word_t     fwd_1c,
    input  cpu_decode_pkg::word_t     fwd_2c,
    input  cpu_decode_pkg::word_t     fwd_3c,
    output cpu_decode_pkg::word_t     operand
);

    logic src_live;   // x0 is hardwired, never forwarded
    logic hit_1c, hit_2c, hit_3c;

    assign src_live = enable_forwarding && (src_addr != '0);

    assign hit_1c = src_live && (src_addr == rd_1c);
    assign hit_2c = src_live && (src_addr == rd_2c);
    assign hit_3c = src_live && (src_addr == rd_3c);

    // youngest writer wins, register file only when nothing in flight matches
    always_comb begin
        if (hit_1c) begin
            operand = fwd_1c;
        end else if (hit_2c) begin
            operand = fwd_2c;
        end else if (hit_3c) begin
            operand = fwd_3c;
        end else begin
            operand = rf_data;
        end
    end

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/10ps

module instr_decoder (
    input  cpu_decode_pkg::word_t     instr,
    input  cpu_decode_pkg::word_t     rs1_val,     // already forwarded
    input  cpu_decode_pkg::word_t     rs2_val,     // already forwarded
    output cpu_decode_pkg::reg_addr_t rs1_addr,
    output cpu_decode_pkg::reg_addr_t rs2_addr,
    output cpu_decode_pkg::reg_addr_t rd_addr,
    output cpu_decode_pkg::word_t     alu_a,
    output cpu_decode_pkg::word_t     alu_b,
    output cpu_decode_pkg::alu_op_e   alu_op,
    output cpu_decode_pkg::mem_op_e   mem_op,
    output logic                      wb_from_alu,
    output logic                      wb_en,
    output cpu_decode_pkg::wb_type_e  wb_type,
    output cpu_decode_pkg::word_t     store_data,
    output logic                      illegal
);
    import cpu_decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_bit;   // instr[30], selects sub and sra
    word_t      imm_i;
    word_t      imm_s;
    alu_op_e    arith_op;
    wb_type_e   mem_type;
    logic       a_sel_rs1;
    logic       b_sel_rs2;
    logic       b_sel_imm_i;
    logic       b_sel_imm_s;
    logic       sd_sel_rs2;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign alt_bit = instr[30];

    // sign extended immediates
    assign imm_i = {{(xlen-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(xlen-12){instr[31]}}, instr[31:25], instr[11:7]};

    // unknown opcodes and unused funct3 slots
    always_comb begin
        case (opcode)
            opc_load:   illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            opc_store:  illegal = funct3[2] || (funct3 == 3'b011);
            opc_op_imm: illegal = 1'b0;   // every funct3 used
            opc_op:     illegal = 1'b0;
            opc_bubble: illegal = 1'b0;
            default:    illegal = 1'b1;
        endcase
    end

    // funct3 map shared by register-immediate and register-register forms
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == opc_op && alt_bit) ? alu_sub : alu_add;   // addi has no subi
            3'b001:  arith_op = alu_sll;
            3'b010:  arith_op = alu_slt;
            3'b011:  arith_op = alu_sltu;
            3'b100:  arith_op = alu_xor;
            3'b101:  arith_op = alt_bit ? alu_sra : alu_srl;
            3'b110:  arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    // access size, loads and stores share the low three slots
    always_comb begin
        case (funct3)
            3'b000:  mem_type = wb_byte_signed;
            3'b001:  mem_type = wb_half_signed;
            3'b100:  mem_type = wb_byte_unsigned;
            3'b101:  mem_type = wb_half_unsigned;
            default: mem_type = wb_word;   // lw, sw
        endcase
    end

    // control decode, reads only the instruction so the source
    // addresses never depend on forwarded data
    always_comb begin
        rd_addr     = '0;
        rs1_addr    = '0;
        rs2_addr    = '0;
        alu_op      = alu_nop;
        mem_op      = mem_nop;
        wb_from_alu = 1'b0;
        wb_en       = 1'b0;
        wb_type     = wb_word;
        a_sel_rs1   = 1'b0;
        b_sel_rs2   = 1'b0;
        b_sel_imm_i = 1'b0;
        b_sel_imm_s = 1'b0;
        sd_sel_rs2  = 1'b0;

        if (!illegal) begin
            case (opcode)
                opc_load: begin
                    rd_addr     = instr[11:7];
                    rs1_addr    = instr[19:15];
                    alu_op      = alu_add;   // address = rs1 + imm
                    mem_op      = mem_load;
                    wb_en       = 1'b1;      // data comes back from memory
                    wb_type     = mem_type;
                    a_sel_rs1   = 1'b1;
                    b_sel_imm_i = 1'b1;
                end
                opc_store: begin
                    rs1_addr    = instr[19:15];
                    rs2_addr    = instr[24:20];
                    alu_op      = alu_add;
                    mem_op      = mem_store;
                    wb_type     = mem_type;  // write size
                    a_sel_rs1   = 1'b1;
                    b_sel_imm_s = 1'b1;
                    sd_sel_rs2  = 1'b1;      // rs2 travels as store data
                end
                opc_op_imm: begin
                    rd_addr     = instr[11:7];
                    rs1_addr    = instr[19:15];
                    alu_op      = arith_op;
                    wb_from_alu = 1'b1;
                    wb_en       = 1'b1;
                    a_sel_rs1   = 1'b1;
                    b_sel_imm_i = 1'b1;      // shamt sits in imm[4:0]
                end
                opc_op: begin
                    rd_addr     = instr[11:7];
                    rs1_addr    = instr[19:15];
                    rs2_addr    = instr[24:20];
                    alu_op      = arith_op;
                    wb_from_alu = 1'b1;
                    wb_en       = 1'b1;
                    a_sel_rs1   = 1'b1;
                    b_sel_rs2   = 1'b1;
                end
                default: begin
                    // bubble, defaults already inactive
                end
            endcase
        end
    end

    // operand steering
    assign alu_a = a_sel_rs1 ? rs1_val : '0;

    always_comb begin
        if (b_sel_rs2) begin
            alu_b = rs2_val;
        end else if (b_sel_imm_i) begin
            alu_b = imm_i;
        end else if (b_sel_imm_s) begin
            alu_b = imm_s;
        end else begin
            alu_b = '0;
        end
    end

    assign store_data = sd_sel_rs2 ? rs2_val : '0;

endmodule

// ==== rtl/ctrl_register.sv ====
`timescale 1ns/10ps

module ctrl_register (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      valid_in,
    input  cpu_decode_pkg::reg_addr_t dec_rd_addr,
    input  cpu_decode_pkg::word_t     dec_alu_a,
    input  cpu_decode_pkg::word_t     dec_alu_b,
    input  cpu_decode_pkg::alu_op_e   dec_alu_op,
    input  cpu_decode_pkg::mem_op_e   dec_mem_op,
    input  logic                      dec_wb_from_alu,
    input  logic                      dec_wb_en,
    input  cpu_decode_pkg::wb_type_e  dec_wb_type,
    input  cpu_decode_pkg::word_t     dec_store_data,
    input  logic                      dec_illegal,
    output logic                      ctrl_valid,
    output cpu_decode_pkg::reg_addr_t rd_addr,
    output cpu_decode_pkg::word_t     alu_a,
    output cpu_decode_pkg::word_t     alu_b,
    output cpu_decode_pkg::alu_op_e   alu_op,
    output cpu_decode_pkg::mem_op_e   mem_op,
    output logic                      wb_from_alu,
    output logic                      wb_en,
    output cpu_decode_pkg::wb_type_e  wb_type,
    output cpu_decode_pkg::word_t     store_data,
    output logic                      illegal
);
    import cpu_decode_pkg::*;

    // control fields, an empty slot turns into a null operation
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_valid  <= 1'b0;
            rd_addr     <= '0;
            alu_op      <= alu_nop;
            mem_op      <= mem_nop;
            wb_from_alu <= 1'b0;
            wb_en       <= 1'b0;
            wb_type     <= wb_word;
            illegal     <= 1'b0;
        end else begin
            ctrl_valid  <= valid_in;
            rd_addr     <= valid_in ? dec_rd_addr : '0;
            alu_op      <= valid_in ? dec_alu_op : alu_nop;
            mem_op      <= valid_in ? dec_mem_op : mem_nop;
            wb_from_alu <= valid_in && dec_wb_from_alu;
            wb_en       <= valid_in && dec_wb_en;
            wb_type     <= valid_in ? dec_wb_type : wb_word;
            illegal     <= valid_in && dec_illegal;
        end
    end

    // operand words, zeroed in idle slots
    always_ff @(posedge clk) begin
        alu_a      <= valid_in ? dec_alu_a : '0;
        alu_b      <= valid_in ? dec_alu_b : '0;
        store_data <= valid_in ? dec_store_data : '0;
    end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/10ps

module decode_stage #(
    parameter bit enable_forwarding = 1'b1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cpu_decode_pkg::word_t     instruction,
    input  logic                      instr_valid,
    input  cpu_decode_pkg::reg_addr_t rd_1c,
    input  cpu_decode_pkg::reg_addr_t rd_2c,
    input  cpu_decode_pkg::reg_addr_t rd_3c,
    input  cpu_decode_pkg::word_t     fwd_1c,
    input  cpu_decode_pkg::word_t     fwd_2c,
    input  cpu_decode_pkg::word_t     fwd_3c,
    input  cpu_decode_pkg::word_t     rs1_data,   // register file, same cycle
    input  cpu_decode_pkg::word_t     rs2_data,
    output cpu_decode_pkg::reg_addr_t rs1_addr,
    output cpu_decode_pkg::reg_addr_t rs2_addr,
    output logic                      ctrl_valid,
    output cpu_decode_pkg::reg_addr_t rd_addr,
    output cpu_decode_pkg::word_t     alu_a,
    output cpu_decode_pkg::word_t     alu_b,
    output cpu_decode_pkg::alu_op_e   alu_op,
    output cpu_decode_pkg::mem_op_e   mem_op,
    output logic                      wb_from_alu,
    output logic                      wb_en,
    output cpu_decode_pkg::wb_type_e  wb_type,
    output cpu_decode_pkg::word_t     store_data,
    output logic                      illegal
);
    import cpu_decode_pkg::*;

    // captured instruction and hazard snapshot
    word_t     instr_q;
    logic      valid_q;
    reg_addr_t rd_1c_q, rd_2c_q, rd_3c_q;
    word_t     fwd_1c_q, fwd_2c_q, fwd_3c_q;

    word_t     rs1_fwd, rs2_fwd;   // forwarded source operands

    // decoder outputs into the output register
    reg_addr_t dec_rd_addr;
    word_t     dec_alu_a, dec_alu_b, dec_store_data;
    alu_op_e   dec_alu_op;
    mem_op_e   dec_mem_op;
    logic      dec_wb_from_alu, dec_wb_en, dec_illegal;
    wb_type_e  dec_wb_type;

    instr_capture instr_capture_i (
        .clk, .rst_n, .instruction, .instr_valid,
        .rd_1c, .rd_2c, .rd_3c,
        .fwd_1c, .fwd_2c, .fwd_3c,
        .instr_q, .valid_q,
        .rd_1c_q, .rd_2c_q, .rd_3c_q,
        .fwd_1c_q, .fwd_2c_q, .fwd_3c_q
    );

    // one forwarder per source port
    operand_forward #(.enable_forwarding(enable_forwarding)) rs1_forward_i (
        .src_addr(rs1_addr), .rf_data(rs1_data),
        .rd_1c(rd_1c_q), .rd_2c(rd_2c_q), .rd_3c(rd_3c_q),
        .fwd_1c(fwd_1c_q), .fwd_2c(fwd_2c_q), .fwd_3c(fwd_3c_q),
        .operand(rs1_fwd)
    );

    operand_forward #(.enable_forwarding(enable_forwarding)) rs2_forward_i (
        .src_addr(rs2_addr), .rf_data(rs2_data),
        .rd_1c(rd_1c_q), .rd_2c(rd_2c_q), .rd_3c(rd_3c_q),
        .fwd_1c(fwd_1c_q), .fwd_2c(fwd_2c_q), .fwd_3c(fwd_3c_q),
        .operand(rs2_fwd)
    );

    instr_decoder instr_decoder_i (
        .instr(instr_q), .rs1_val(rs1_fwd), .rs2_val(rs2_fwd),
        .rs1_addr, .rs2_addr,
        .rd_addr(dec_rd_addr), .alu_a(dec_alu_a), .alu_b(dec_alu_b),
        .alu_op(dec_alu_op), .mem_op(dec_mem_op),
        .wb_from_alu(dec_wb_from_alu), .wb_en(dec_wb_en), .wb_type(dec_wb_type),
        .store_data(dec_store_data), .illegal(dec_illegal)
    );

    ctrl_register ctrl_register_i (
        .clk, .rst_n, .valid_in(valid_q),
        .dec_rd_addr, .dec_alu_a, .dec_alu_b, .dec_alu_op, .dec_mem_op,
        .dec_wb_from_alu, .dec_wb_en, .dec_wb_type, .dec_store_data, .dec_illegal,
        .ctrl_valid, .rd_addr, .alu_a, .alu_b, .alu_op, .mem_op,
        .wb_from_alu, .wb_en, .wb_type, .store_data, .illegal
    );

endmodule

// ==== test/decode_stage_checker.sv ====
`timescale 1ns/10ps

module decode_stage_checker (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      ctrl_valid,
    input cpu_decode_pkg::reg_addr_t rd_addr,
    input cpu_decode_pkg::alu_op_e   alu_op,
    input cpu_decode_pkg::mem_op_e   mem_op,
    input logic                      wb_en,
    input logic                      illegal
);
    import cpu_decode_pkg::*;

    // one cycle after a reset edge the stage must be quiet
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!ctrl_valid && !wb_en && !illegal
                    && mem_op == mem_nop && alu_op == alu_nop))
        else $error("outputs active after reset");

    // illegal instructions must not write back or touch memory
    a_illegal_inert: assert property (@(posedge clk) disable iff (!rst_n)
        illegal |-> (!wb_en && mem_op == mem_nop))
        else $error("illegal with active controls");

    a_store_no_rd: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_op == mem_store) |-> (rd_addr == '0))   // stores have no destination
        else $error("store with nonzero rd");

endmodule

// ==== test/decode_stage_tb.sv ====
`timescale 1ns/10ps

module decode_stage_tb;
    import cpu_decode_pkg::*;

    typedef struct packed {
        logic        valid;
        logic [4:0]  ra1;     // source addresses seen in the capture cycle
        logic [4:0]  ra2;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  op;
        logic [1:0]  mem;
        logic        from_alu;
        logic        wen;
        logic [2:0]  wtype;
        logic [31:0] sdata;
        logic        ill;
    } exp_t;

    logic      clk, rst_n, instr_valid, ctrl_valid, wb_from_alu, wb_en, illegal;
    word_t     instruction, fwd_1c, fwd_2c, fwd_3c, rs1_data, rs2_data;
    word_t     alu_a, alu_b, store_data;
    reg_addr_t rd_1c, rd_2c, rd_3c, rs1_addr, rs2_addr, rd_addr;
    alu_op_e   alu_op;
    mem_op_e   mem_op;
    wb_type_e  wb_type;
    exp_t      exp_q[$];
    int        errors = 0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    decode_stage #(.enable_forwarding(1'b1)) decode_stage_i (.*);

    bind decode_stage decode_stage_checker checker_i (.*);

    // register file contents, x0 reads zero
    function automatic word_t rf_word(input reg_addr_t i);
        return (i == 0) ? 32'h0 : ((32'(i) * 32'h9e37_79b1) ^ {27'h5a5a5a5, i});
    endfunction

    assign rs1_data = rf_word(rs1_addr);   // same-cycle read
    assign rs2_data = rf_word(rs2_addr);

    function automatic word_t pick_operand(input reg_addr_t src, input reg_addr_t r1,
            input reg_addr_t r2, input reg_addr_t r3, input word_t f1, input word_t f2,
            input word_t f3);
        if (src == 0) return 32'h0;
        if (src == r1) return f1;      // youngest first
        if (src == r2) return f2;
        if (src == r3) return f3;
        return rf_word(src);
    endfunction

    function automatic exp_t ref_decode(input word_t ins, input logic v, input reg_addr_t r1,
            input reg_addr_t r2, input reg_addr_t r3, input word_t f1, input word_t f2,
            input word_t f3);
        exp_t  e;
        word_t s1, s2, imm_i, imm_s;
        logic [2:0] f3b;
        e = '0;
        if (!v) return e;
        e.valid = 1'b1;
        f3b = ins[14:12];
        s1 = pick_operand(ins[19:15], r1, r2, r3, f1, f2, f3);
        s2 = pick_operand(ins[24:20], r1, r2, r3, f1, f2, f3);
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        case (ins[6:0])
            7'h03, 7'h23: begin
                if (f3b == 3'd3 || f3b == 3'd6 || f3b == 3'd7 || (ins[5] && f3b > 3'd2)) begin
                    e.ill = 1'b1;
                end else begin
                    e.op  = alu_add;
                    e.a   = s1;
                    e.ra1 = ins[19:15];
                    case (f3b)
                        3'd0: e.wtype = wb_byte_signed;
                        3'd1: e.wtype = wb_half_signed;
                        3'd4: e.wtype = wb_byte_unsigned;
                        3'd5: e.wtype = wb_half_unsigned;
                        default: e.wtype = wb_word;
                    endcase
                    if (ins[5]) begin   // store
                        e.mem   = mem_store;
                        e.b     = imm_s;
                        e.sdata = s2;
                        e.ra2   = ins[24:20];
                    end else begin
                        e.mem = mem_load;
                        e.b   = imm_i;
                        e.rd  = ins[11:7];
                        e.wen = 1'b1;
                    end
                end
            end
            7'h13, 7'h33: begin
                e.rd = ins[11:7];
                e.a = s1;
                e.b = ins[5] ? s2 : imm_i;
                e.ra1 = ins[19:15];
                e.ra2 = ins[5] ? ins[24:20] : 5'd0;   // rs2 only for register-register
                e.wen = 1'b1;
                e.from_alu = 1'b1;
                case (f3b)
                    3'd0: e.op = (ins[5] && ins[30]) ? alu_sub : alu_add;
                    3'd1: e.op = alu_sll;
                    3'd2: e.op = alu_slt;
                    3'd3: e.op = alu_sltu;
                    3'd4: e.op = alu_xor;
                    3'd5: e.op = ins[30] ? alu_sra : alu_srl;
                    3'd6: e.op = alu_or;
                    default: e.op = alu_and;
                endcase
            end
            7'h00: ;   // bubble, nothing active
            default: e.ill = 1'b1;
        endcase
        return e;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // scoreboard, outputs are stable mid-cycle
    initial begin
        exp_t e;
        exp_t nxt;
        forever begin
            @(negedge clk);
            if (exp_q.size() > 2) begin
                e = exp_q.pop_front();
                compare_value("ctrl_valid", 32'(ctrl_valid), 32'(e.valid));
                compare_value("rd_addr", 32'(rd_addr), 32'(e.rd));
                compare_value("alu_a", alu_a, e.a);
                compare_value("alu_b", alu_b, e.b);
                compare_value("alu_op", 32'(alu_op), 32'(e.op));
                compare_value("mem_op", 32'(mem_op), 32'(e.mem));
                compare_value("wb_from_alu", 32'(wb_from_alu), 32'(e.from_alu));
                compare_value("wb_en", 32'(wb_en), 32'(e.wen));
                compare_value("wb_type", 32'(wb_type), 32'(e.wtype));
                compare_value("store_data", store_data, e.sdata);
                compare_value("illegal", 32'(illegal), 32'(e.ill));
                // register file addresses follow the instruction now in capture
                nxt = exp_q[0];
                compare_value("rs1_addr", 32'(rs1_addr), 32'(nxt.ra1));
                compare_value("rs2_addr", 32'(rs2_addr), 32'(nxt.ra2));
            end
        end
    end

    task automatic drive_cycle(input logic v, input word_t ins, input reg_addr_t r1,
            input reg_addr_t r2, input reg_addr_t r3);
        @(posedge clk);
        #1;
        instr_valid = v;
        instruction = ins;
        rd_1c  = r1;
        rd_2c  = r2;
        rd_3c  = r3;
        fwd_1c = $urandom;
        fwd_2c = $urandom;
        fwd_3c = $urandom;
        exp_q.push_back(ref_decode(ins, v, r1, r2, r3, fwd_1c, fwd_2c, fwd_3c));
    endtask

    function automatic word_t random_instr();
        logic [6:0] opc;
        int kind;
        kind = $urandom_range(0, 9);
        case (kind)
            0, 1:    opc = 7'h03;
            2, 3:    opc = 7'h23;
            4, 5:    opc = 7'h13;
            6, 7:    opc = 7'h33;
            8:       opc = 7'h00;
            default: opc = 7'($urandom);   // mostly unknown opcodes
        endcase
        if (opc == 7'h00) return 32'h0;
        // registers kept small so forwarding hits often
        return {7'($urandom), 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                3'($urandom), 5'($urandom_range(0, 7)), opc};
    endfunction

    initial begin
        int waited;
        void'($urandom(29));
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instruction = '0;
        {rd_1c, rd_2c, rd_3c} = '0;
        {fwd_1c, fwd_2c, fwd_3c} = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        exp_q.push_back('0);   // idle slot right after reset
        // forwarding priority on add x5, x5, x5
        drive_cycle(1'b1, 32'h0052_82b3, 5'd5, 5'd5, 5'd5);
        drive_cycle(1'b1, 32'h0052_82b3, 5'd1, 5'd5, 5'd5);
        drive_cycle(1'b1, 32'h0052_82b3, 5'd1, 5'd2, 5'd5);
        drive_cycle(1'b1, 32'h0052_82b3, 5'd1, 5'd2, 5'd3);
        drive_cycle(1'b1, 32'h0000_0033, 5'd0, 5'd0, 5'd0);   // x0 sources
        drive_cycle(1'b1, 32'h0052_a223, 5'd5, 5'd0, 5'd5);   // sw x5, 4(x5)
        drive_cycle(1'b1, 32'hfff2_8293, 5'd0, 5'd0, 5'd0);   // addi with -1
        drive_cycle(1'b1, 32'h4052_d293, 5'd0, 5'd0, 5'd0);   // srai
        drive_cycle(1'b0, 32'h0, 5'd0, 5'd0, 5'd0);
        drive_cycle(1'b1, 32'h0, 5'd0, 5'd0, 5'd0);           // valid bubble
        drive_cycle(1'b1, 32'h0002_b283, 5'd0, 5'd0, 5'd0);   // load funct3 3
        drive_cycle(1'b1, 32'h0052_c223, 5'd0, 5'd0, 5'd0);   // store funct3 4
        drive_cycle(1'b1, 32'h0000_007f, 5'd0, 5'd0, 5'd0);   // unknown opcode
        repeat (500) begin
            drive_cycle($urandom_range(0, 3) != 0, random_instr(),
                        5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)),
                        5'($urandom_range(0, 7)));
        end
        // two idle slots push the last instruction through the pipe
        drive_cycle(1'b0, 32'h0, 5'd0, 5'd0, 5'd0);
        drive_cycle(1'b0, 32'h0, 5'd0, 5'd0, 5'd0);
        waited = 0;
        while (exp_q.size() > 2 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        #1;
        if (exp_q.size() > 2) begin
            $display("timeout while draining the scoreboard");
            $display("Testbench failed");
            $fatal(1);
        end else if (errors == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1);
        end
    end

    // hard limit on simulated time
    initial begin
        #20000;
        $display("simulation ran past its time limit");
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

// ==== sources.f ====
rtl/cpu_decode_pkg.sv
rtl/instr_capture.sv
rtl/operand_forward.sv
rtl/instr_decoder.sv
rtl/ctrl_register.sv
rtl/decode_stage.sv
test/decode_stage_checker.sv
test/decode_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module decode_stage_tb -f sources.f -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/decode_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
